// ==== Bender.yml ====
package:
  name: imuldiv

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/imuldiv_pkg.sv
      - hdl/imuldiv_mul_iterative.sv
      - hdl/imuldiv_div_iterative.sv
      - hdl/imuldiv_muldiv_iterative.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/imuldiv_assertions.sv
      - testbench/tb_imuldiv.sv

// ==== all.f ====
+incdir+hdl
hdl/imuldiv_pkg.sv
hdl/imuldiv_mul_iterative.sv
hdl/imuldiv_div_iterative.sv
hdl/imuldiv_muldiv_iterative.sv
testbench/imuldiv_assertions.sv
testbench/tb_imuldiv.sv

// ==== hdl/imuldiv_config.svh ====
//------------------------------------------------------------
// width macros for the iterative mul/div unit
//------------------------------------------------------------

`ifndef IMULDIV_CONFIG_SVH
`define IMULDIV_CONFIG_SVH

// operand width, responses carry twice this many bits
`define IMULDIV_XLEN 32

// iteration counter width
// counts from XLEN-1 down to zero, one step per cycle
`define IMULDIV_CNT_W 5

`endif

// ==== hdl/imuldiv_div_iterative.sv ====
//------------------------------------------------------------
// iterative restoring divider: datapath, control FSM, wrapper
//------------------------------------------------------------

`timescale 1ns/1ns
`include "imuldiv_config.svh"

module imuldiv_div_dpath import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  div_req_t    req,
  input  logic        a_en,
  input  logic        a_mux_sel,
  input  logic        b_en,
  input  logic        rem_en,
  input  logic        rem_mux_sel,
  input  logic        quot_bit_sel,
  input  logic        cntr_mux_sel,
  input  logic        sign_en,
  input  logic        sign_mux_sel,
  input  logic        dz_mux_sel,
  output logic        counter_is_zero,
  output logic        diff_neg,
  output logic        is_div_zero,
  output logic        sign,
  output logic [63:0] result
);

  localparam int XLEN = `IMULDIV_XLEN;
  localparam logic [`IMULDIV_CNT_W-1:0] CNT_INIT = `IMULDIV_CNT_W'(XLEN - 1);

  logic [XLEN-1:0]           a_reg;
  logic [XLEN-1:0]           b_reg;
  logic [2*XLEN-1:0]         rem_reg;
  logic [`IMULDIV_CNT_W-1:0] cntr_reg;
  logic                      q_neg_reg;
  logic                      r_neg_reg;
  logic                      dz_reg;
  logic [XLEN-1:0]           a_mag;
  logic [XLEN-1:0]           b_mag;
  logic [2*XLEN-1:0]         rem_shift;
  logic [2*XLEN-1:0]         diff;
  logic [2*XLEN-1:0]         rem_step;
  logic [XLEN-1:0]           quot_fix;
  logic [XLEN-1:0]           rem_fix;

  // magnitudes only for signed requests
  assign a_mag = (req.is_signed && req.a[XLEN-1]) ? -req.a : req.a;
  assign b_mag = (req.is_signed && req.b[XLEN-1]) ? -req.b : req.b;

  //------------------------------------------------------------
  // restoring step
  //------------------------------------------------------------
  // next dividend bit enters the partial remainder from the left
  assign rem_shift = {rem_reg[2*XLEN-2:0], a_reg[XLEN-1]};
  assign diff      = rem_shift - {{XLEN{1'b0}}, b_reg};
  // partial remainder stays below 2^33, so the msb is a true sign
  assign diff_neg  = diff[2*XLEN-1];
  assign rem_step  = quot_bit_sel ? diff : rem_shift;

  always_ff @(posedge clk) begin
    // quotient bits shift in behind the dividend bits
    if (a_en) begin
      a_reg <= a_mux_sel ? {a_reg[XLEN-2:0], quot_bit_sel} : a_mag;
    end
    if (b_en) begin
      b_reg <= b_mag;
    end
    if (rem_en) begin
      rem_reg <= rem_mux_sel ? rem_step : '0;
    end
  end

  // result signs and divide-by-zero, captured at accept
  always_ff @(posedge clk) begin
    if (sign_en) begin
      q_neg_reg <= req.is_signed && (req.a[XLEN-1] ^ req.b[XLEN-1]);
      r_neg_reg <= req.is_signed && req.a[XLEN-1];
      dz_reg    <= (req.b == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cntr_reg <= '0;
    end else begin
      cntr_reg <= cntr_mux_sel ? cntr_reg - 1'b1 : CNT_INIT;
    end
  end

  assign counter_is_zero = (cntr_reg == '0);
  assign is_div_zero     = dz_reg;
  assign sign            = q_neg_reg | r_neg_reg;

  //------------------------------------------------------------
  // output: {remainder, quotient} with signs applied
  //------------------------------------------------------------
  assign quot_fix = (sign_mux_sel && q_neg_reg) ? -a_reg : a_reg;
  assign rem_fix  = (sign_mux_sel && r_neg_reg) ? -rem_reg[XLEN-1:0] : rem_reg[XLEN-1:0];

  // on a zero divisor the remainder already equals the dividend
  assign result = {rem_fix, dz_mux_sel ? {XLEN{1'b1}} : quot_fix};

endmodule

module imuldiv_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  input  logic counter_is_zero,
  input  logic diff_neg,
  input  logic is_div_zero,
  input  logic sign,
  output logic req_rdy,
  output logic resp_val,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic rem_en,
  output logic rem_mux_sel,
  output logic quot_bit_sel,
  output logic cntr_mux_sel,
  output logic sign_en,
  output logic sign_mux_sel,
  output logic dz_mux_sel
);

  typedef enum logic [1:0] {IDLE, CALC, DONE} state_e;

  state_e state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (req_val) begin
            state <= CALC;
          end
        end
        CALC: begin
          if (counter_is_zero) begin
            state <= DONE;
          end
        end
        // hold the result under back-pressure
        DONE: begin
          if (resp_rdy) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_comb begin
    req_rdy      = 1'b0;
    resp_val     = 1'b0;
    a_en         = 1'b0;
    a_mux_sel    = 1'b0;
    b_en         = 1'b0;
    rem_en       = 1'b0;
    rem_mux_sel  = 1'b0;
    quot_bit_sel = 1'b0;
    cntr_mux_sel = 1'b0;
    sign_en      = 1'b0;
    sign_mux_sel = 1'b0;
    dz_mux_sel   = 1'b0;
    case (state)
      IDLE: begin
        req_rdy = 1'b1;
        a_en    = req_val;
        b_en    = req_val;
        rem_en  = req_val;
        sign_en = req_val;
      end
      CALC: begin
        a_en         = 1'b1;
        a_mux_sel    = 1'b1;
        rem_en       = 1'b1;
        rem_mux_sel  = 1'b1;
        // keep the difference only when it did not go negative
        quot_bit_sel = ~diff_neg;
        cntr_mux_sel = 1'b1;
      end
      DONE: begin
        resp_val     = 1'b1;
        sign_mux_sel = sign;
        dz_mux_sel   = is_div_zero;
      end
      default: ;
    endcase
  end

endmodule

module imuldiv_div_iterative import imuldiv_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  div_req_t     req_msg,
  input  logic         req_val,
  output logic         req_rdy,
  output muldiv_resp_t resp_msg,
  output logic         resp_val,
  input  logic         resp_rdy
);

  logic a_en;
  logic a_mux_sel;
  logic b_en;
  logic rem_en;
  logic rem_mux_sel;
  logic quot_bit_sel;
  logic cntr_mux_sel;
  logic sign_en;
  logic sign_mux_sel;
  logic dz_mux_sel;
  logic counter_is_zero;
  logic diff_neg;
  logic is_div_zero;
  logic sign;

  imuldiv_div_dpath dpath (
    .clk             (clk),
    .reset           (reset),
    .req             (req_msg),
    .a_en            (a_en),
    .a_mux_sel       (a_mux_sel),
    .b_en            (b_en),
    .rem_en          (rem_en),
    .rem_mux_sel     (rem_mux_sel),
    .quot_bit_sel    (quot_bit_sel),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en),
    .sign_mux_sel    (sign_mux_sel),
    .dz_mux_sel      (dz_mux_sel),
    .counter_is_zero (counter_is_zero),
    .diff_neg        (diff_neg),
    .is_div_zero     (is_div_zero),
    .sign            (sign),
    .result          (resp_msg.result)
  );

  imuldiv_div_ctrl ctrl (
    .clk             (clk),
    .reset           (reset),
    .req_val         (req_val),
    .resp_rdy        (resp_rdy),
    .counter_is_zero (counter_is_zero),
    .diff_neg        (diff_neg),
    .is_div_zero     (is_div_zero),
    .sign            (sign),
    .req_rdy         (req_rdy),
    .resp_val        (resp_val),
    .a_en            (a_en),
    .a_mux_sel       (a_mux_sel),
    .b_en            (b_en),
    .rem_en          (rem_en),
    .rem_mux_sel     (rem_mux_sel),
    .quot_bit_sel    (quot_bit_sel),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en),
    .sign_mux_sel    (sign_mux_sel),
    .dz_mux_sel      (dz_mux_sel)
  );

endmodule

// ==== hdl/imuldiv_mul_iterative.sv ====
//------------------------------------------------------------
// iterative signed multiplier: datapath, control FSM, wrapper
//------------------------------------------------------------

`timescale 1ns/1ns
`include "imuldiv_config.svh"

module imuldiv_mul_dpath import imuldiv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  operands_t   req,
  input  logic        a_en,
  input  logic        a_mux_sel,
  input  logic        b_en,
  input  logic        b_mux_sel,
  input  logic        result_en,
  input  logic        result_mux_sel,
  input  logic        add_mux_sel,
  input  logic        cntr_mux_sel,
  input  logic        sign_en,
  input  logic        sign_mux_sel,
  output logic        counter_is_zero,
  output logic        b_lsb,
  output logic        sign,
  output logic [63:0] result
);

  localparam int XLEN = `IMULDIV_XLEN;
  localparam logic [`IMULDIV_CNT_W-1:0] CNT_INIT = `IMULDIV_CNT_W'(XLEN - 1);

  logic [2*XLEN-1:0]         a_reg;
  logic [XLEN-1:0]           b_reg;
  logic [2*XLEN-1:0]         acc_reg;
  logic [`IMULDIV_CNT_W-1:0] cntr_reg;
  logic                      sign_reg;
  logic [XLEN-1:0]           a_mag;
  logic [XLEN-1:0]           b_mag;
  logic [2*XLEN-1:0]         add_out;
  logic [2*XLEN-1:0]         add_mux_out;

  // operand magnitudes, sign is fixed up in DONE
  assign a_mag = req.a[XLEN-1] ? -req.a : req.a;
  assign b_mag = req.b[XLEN-1] ? -req.b : req.b;

  // multiplicand moves left each step, multiplier moves right
  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_sel ? (a_reg << 1) : {{XLEN{1'b0}}, a_mag};
    end
    if (b_en) begin
      b_reg <= b_mux_sel ? (b_reg >> 1) : b_mag;
    end
  end

  assign b_lsb = b_reg[0];

  // accumulate the multiplicand when the multiplier lsb is set
  assign add_out     = acc_reg + a_reg;
  assign add_mux_out = add_mux_sel ? add_out : acc_reg;

  always_ff @(posedge clk) begin
    if (result_en) begin
      acc_reg <= result_mux_sel ? add_mux_out : '0;
    end
    if (sign_en) begin
      sign_reg <= req.a[XLEN-1] ^ req.b[XLEN-1];
    end
  end

  // iteration counter, reloaded whenever not calculating
  always_ff @(posedge clk) begin
    if (reset) begin
      cntr_reg <= '0;
    end else begin
      cntr_reg <= cntr_mux_sel ? cntr_reg - 1'b1 : CNT_INIT;
    end
  end

  assign counter_is_zero = (cntr_reg == '0);
  assign sign            = sign_reg;

  // two's complement of the magnitude when the product is negative
  assign result = sign_mux_sel ? -acc_reg : acc_reg;

endmodule

module imuldiv_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  input  logic counter_is_zero,
  input  logic b_lsb,
  input  logic sign,
  output logic req_rdy,
  output logic resp_val,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic b_mux_sel,
  output logic result_en,
  output logic result_mux_sel,
  output logic add_mux_sel,
  output logic cntr_mux_sel,
  output logic sign_en,
  output logic sign_mux_sel
);

  typedef enum logic [1:0] {IDLE, CALC, DONE} state_e;

  state_e state;

  //------------------------------------------------------------
  // state register
  //------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (req_val) begin
            state <= CALC;
          end
        end
        // last step happens while the counter reads zero
        CALC: begin
          if (counter_is_zero) begin
            state <= DONE;
          end
        end
        DONE: begin
          if (resp_rdy) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  //------------------------------------------------------------
  // datapath enables and selects
  //------------------------------------------------------------
  always_comb begin
    req_rdy        = 1'b0;
    resp_val       = 1'b0;
    a_en           = 1'b0;
    a_mux_sel      = 1'b0;
    b_en           = 1'b0;
    b_mux_sel      = 1'b0;
    result_en      = 1'b0;
    result_mux_sel = 1'b0;
    add_mux_sel    = 1'b0;
    cntr_mux_sel   = 1'b0;
    sign_en        = 1'b0;
    sign_mux_sel   = 1'b0;
    case (state)
      IDLE: begin
        req_rdy   = 1'b1;
        // load magnitudes, clear the accumulator, latch the sign
        a_en      = req_val;
        b_en      = req_val;
        result_en = req_val;
        sign_en   = req_val;
      end
      CALC: begin
        a_en           = 1'b1;
        a_mux_sel      = 1'b1;
        b_en           = 1'b1;
        b_mux_sel      = 1'b1;
        result_en      = 1'b1;
        result_mux_sel = 1'b1;
        add_mux_sel    = b_lsb;
        cntr_mux_sel   = 1'b1;
      end
      DONE: begin
        resp_val     = 1'b1;
        sign_mux_sel = sign;
      end
      default: ;
    endcase
  end

endmodule

module imuldiv_mul_iterative import imuldiv_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  operands_t    req_msg,
  input  logic         req_val,
  output logic         req_rdy,
  output muldiv_resp_t resp_msg,
  output logic         resp_val,
  input  logic         resp_rdy
);

  logic a_en;
  logic a_mux_sel;
  logic b_en;
  logic b_mux_sel;
  logic result_en;
  logic result_mux_sel;
  logic add_mux_sel;
  logic cntr_mux_sel;
  logic sign_en;
  logic sign_mux_sel;
  logic counter_is_zero;
  logic b_lsb;
  logic sign;

  imuldiv_mul_dpath dpath (
    .clk             (clk),
    .reset           (reset),
    .req             (req_msg),
    .a_en            (a_en),
    .a_mux_sel       (a_mux_sel),
    .b_en            (b_en),
    .b_mux_sel       (b_mux_sel),
    .result_en       (result_en),
    .result_mux_sel  (result_mux_sel),
    .add_mux_sel     (add_mux_sel),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en),
    .sign_mux_sel    (sign_mux_sel),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb),
    .sign            (sign),
    .result          (resp_msg.result)
  );

  imuldiv_mul_ctrl ctrl (
    .clk             (clk),
    .reset           (reset),
    .req_val         (req_val),
    .resp_rdy        (resp_rdy),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb),
    .sign            (sign),
    .req_rdy         (req_rdy),
    .resp_val        (resp_val),
    .a_en            (a_en),
    .a_mux_sel       (a_mux_sel),
    .b_en            (b_en),
    .b_mux_sel       (b_mux_sel),
    .result_en       (result_en),
    .result_mux_sel  (result_mux_sel),
    .add_mux_sel     (add_mux_sel),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en),
    .sign_mux_sel    (sign_mux_sel)
  );

endmodule

// ==== hdl/imuldiv_muldiv_iterative.sv ====
//------------------------------------------------------------
// mul/div top level: dispatch by fn, one operation in flight
//------------------------------------------------------------

`timescale 1ns/1ns

module imuldiv_muldiv_iterative import imuldiv_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  muldiv_req_t  req_msg,
  input  logic         req_val,
  output logic         req_rdy,
  output muldiv_resp_t resp_msg,
  output logic         resp_val,
  input  logic         resp_rdy
);

  typedef enum logic [1:0] {OWN_NONE, OWN_MUL, OWN_DIV} owner_e;

  owner_e       owner;
  logic         is_mul;
  operands_t    mul_req;
  div_req_t     div_req;
  logic         mul_req_val;
  logic         mul_req_rdy;
  logic         div_req_val;
  logic         div_req_rdy;
  muldiv_resp_t mul_resp;
  muldiv_resp_t div_resp;
  logic         mul_resp_val;
  logic         div_resp_val;

  //------------------------------------------------------------
  // request dispatch
  //------------------------------------------------------------
  // anything other than fn_mul goes to the divider
  assign is_mul  = (req_msg.fn == fn_mul);
  assign mul_req = '{a: req_msg.a, b: req_msg.b};
  assign div_req = '{is_signed: (req_msg.fn == fn_div), a: req_msg.a, b: req_msg.b};

  // only the selected unit sees val, and only when nothing is owed
  assign mul_req_val = req_val && (owner == OWN_NONE) && is_mul;
  assign div_req_val = req_val && (owner == OWN_NONE) && !is_mul;
  assign req_rdy     = (owner == OWN_NONE) && (is_mul ? mul_req_rdy : div_req_rdy);

  // owner is set on accept and cleared once the response leaves
  always_ff @(posedge clk) begin
    if (reset) begin
      owner <= OWN_NONE;
    end else if (req_val && req_rdy) begin
      owner <= is_mul ? OWN_MUL : OWN_DIV;
    end else if (resp_val && resp_rdy) begin
      owner <= OWN_NONE;
    end
  end

  imuldiv_mul_iterative mul (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (mul_req),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_msg (mul_resp),
    .resp_val (mul_resp_val),
    .resp_rdy (resp_rdy && (owner == OWN_MUL))
  );

  imuldiv_div_iterative div (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (div_req),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_msg (div_resp),
    .resp_val (div_resp_val),
    .resp_rdy (resp_rdy && (owner == OWN_DIV))
  );

  //------------------------------------------------------------
  // response steering from the owning unit
  //------------------------------------------------------------
  assign resp_val = (owner == OWN_MUL) ? mul_resp_val :
                    (owner == OWN_DIV) ? div_resp_val : 1'b0;
  assign resp_msg = (owner == OWN_MUL) ? mul_resp : div_resp;

endmodule

// ==== hdl/imuldiv_pkg.sv ====
//------------------------------------------------------------
// operation codes and the request/response message structs
//------------------------------------------------------------

`include "imuldiv_config.svh"

package imuldiv_pkg;

  // operation select carried in the top-level request
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } muldiv_fn_e;

  // top-level request
  typedef struct packed {
    muldiv_fn_e               fn;
    logic [`IMULDIV_XLEN-1:0] a;
    logic [`IMULDIV_XLEN-1:0] b;
  } muldiv_req_t;

  // multiplier request, always signed
  typedef struct packed {
    logic [`IMULDIV_XLEN-1:0] a;
    logic [`IMULDIV_XLEN-1:0] b;
  } operands_t;

  // divider request
  typedef struct packed {
    logic                     is_signed;
    logic [`IMULDIV_XLEN-1:0] a;
    logic [`IMULDIV_XLEN-1:0] b;
  } div_req_t;

  // shared response, div packs {remainder, quotient}
  typedef struct packed {
    logic [2*`IMULDIV_XLEN-1:0] result;
  } muldiv_resp_t;

endpackage

// ==== testbench/imuldiv_assertions.sv ====
//------------------------------------------------------------
// concurrent handshake checks bound to the mul/div top level
//------------------------------------------------------------

`timescale 1ns/1ns

module imuldiv_assertions import imuldiv_pkg::*; (
  input logic         clk,
  input logic         reset,
  input logic         req_val,
  input logic         req_rdy,
  input logic         resp_val,
  input logic         resp_rdy,
  input muldiv_resp_t resp_msg
);

  // high from a request transfer until its response transfers
  logic pending;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (req_val && req_rdy) begin
      pending <= 1'b1;
    end else if (resp_val && resp_rdy) begin
      pending <= 1'b0;
    end
  end

  // a response only shows up while a unit owns the operation
  assert property (@(posedge clk) disable iff (reset) $rose(resp_val) |-> !req_rdy)
    else $error("resp_val rose while req_rdy was high");

  // stalled response holds its value
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_msg)))
    else $error("response changed or dropped while stalled");

  // no second request while one is unreturned
  assert property (@(posedge clk) disable iff (reset) pending |-> !req_rdy)
    else $error("req_rdy high while an operation is unreturned");

endmodule

bind imuldiv_muldiv_iterative imuldiv_assertions assertions_inst (
  .clk      (clk),
  .reset    (reset),
  .req_val  (req_val),
  .req_rdy  (req_rdy),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy),
  .resp_msg (resp_msg)
);

// ==== testbench/imuldiv_patterns.txt ====
// columns: fn_a_b_expected, fn 0 = mul, 1 = signed div, 2 = unsigned div
// expected is the 64-bit product, or {remainder, quotient} for a divide
0_00000003_00000005_000000000000000f
0_fffffffd_00000005_fffffffffffffff1
0_fffffff9_fffffffa_000000000000002a
0_00000000_12345678_0000000000000000
0_7fffffff_7fffffff_3fffffff00000001
0_80000000_ffffffff_0000000080000000
0_80000000_80000000_4000000000000000
0_80000000_7fffffff_c000000080000000
0_12345678_00000010_0000000123456780
0_ffffffff_ffffffff_0000000000000001
0_00000001_80000000_ffffffff80000000
1_00000014_00000003_0000000200000006
1_ffffffec_00000003_fffffffefffffffa
1_00000014_fffffffd_00000002fffffffa
1_ffffffec_fffffffd_fffffffe00000006
1_80000000_ffffffff_0000000080000000
1_7fffffff_00000010_0000000f07ffffff
1_ffffff9c_00000007_fffffffefffffff2
2_ffffffff_00000010_0000000f0fffffff
2_80000000_00000003_000000022aaaaaaa
2_fffffffe_ffffffff_fffffffe00000000
2_90000000_80000000_1000000000000001
2_ffffffec_00000003_000000025555554e
1_00001234_00000000_00001234ffffffff
1_fffffff0_00000000_fffffff0ffffffff
2_87654321_00000000_87654321ffffffff

// ==== testbench/tb_imuldiv.sv ====
//------------------------------------------------------------
// testbench for the iterative mul/div top level, pattern driven
//------------------------------------------------------------

`timescale 1ns/1ns
`include "imuldiv_config.svh"

module tb_imuldiv import imuldiv_pkg::*;;

  localparam int XLEN           = `IMULDIV_XLEN;
  localparam int PAT_W          = 4 + 4 * XLEN;
  localparam int MAX_PATTERNS   = 64;
  localparam int TIMEOUT_CYCLES = 100;
  localparam int RESP_LATENCY   = 33;
  localparam int DRIVE_DELAY    = 2;

  logic         clk;
  logic         reset;
  muldiv_req_t  req_msg;
  logic         req_val;
  logic         req_rdy;
  muldiv_resp_t resp_msg;
  logic         resp_val;
  logic         resp_rdy;

  // each pattern word holds fn, a, b and the expected result
  logic [PAT_W-1:0] patterns [0:MAX_PATTERNS-1];
  int               num_patterns;
  int               cycle;
  int               tx_count;
  int               rx_count;
  int               error_count;
  int               timeout_count;
  bit               random_ready;
  bit               check_latency;
  bit               val_seen;
  // pattern index and accept cycle of each unreturned request
  int               expect_q[$];
  int               accept_q[$];

  imuldiv_muldiv_iterative imuldiv_muldiv_iterative_inst (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  always #20 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // consumer ready is held high or toggled at random
  initial begin
    int seed_value;
    seed_value = $urandom(32'h00ee_407b);
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      resp_rdy = random_ready ? (($urandom % 3) != 0) : 1'b1;
    end
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  //------------------------------------------------------------
  // response monitor sampling mid-cycle
  //------------------------------------------------------------
  always @(negedge clk) begin
    int idx;
    if (!reset) begin
      // nothing new accepted while an operation is owed
      if (expect_q.size() > 0) begin
        check_value("req_rdy", 64'd0, req_rdy);
      end
      if (resp_val && expect_q.size() == 0) begin
        $display("%0t resp_val is high with no request outstanding", $time);
        error_count++;
      end else if (resp_val) begin
        if (!val_seen && check_latency) begin
          check_value("resp_val latency", RESP_LATENCY, cycle + 1 - accept_q[0]);
        end
        val_seen = 1'b1;
        if (resp_rdy) begin
          idx = expect_q.pop_front();
          void'(accept_q.pop_front());
          check_value($sformatf("resp_msg.result[%0d]", idx),
                      patterns[idx][2*XLEN-1:0], resp_msg.result);
          rx_count++;
          val_seen = 1'b0;
        end
      end
    end
  end

  // starts and returns just after a drive point
  task automatic send_request(input int idx);
    int waited;
    waited       = 0;
    req_msg.fn   = muldiv_fn_e'(patterns[idx][4*XLEN+1:4*XLEN]);
    req_msg.a    = patterns[idx][4*XLEN-1:3*XLEN];
    req_msg.b    = patterns[idx][3*XLEN-1:2*XLEN];
    req_val      = 1'b1;
    @(negedge clk);
    while (!req_rdy && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (!req_rdy) begin
      $display("%0t timeout: req_rdy never came back for request %0d", $time, idx);
      timeout_count++;
      return;
    end
    @(posedge clk);
    #DRIVE_DELAY;
    expect_q.push_back(idx);
    accept_q.push_back(cycle);
    tx_count++;
    req_val = 1'b0;
    req_msg = '0;
  endtask

  task automatic wait_for_responses(input int target);
    int waited;
    waited = 0;
    while (rx_count < target && waited < TIMEOUT_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    if (rx_count < target) begin
      $display("%0t timeout: resp_val handshake stalled, %0d of %0d responses seen",
               $time, rx_count, target);
      timeout_count++;
    end
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // one pass over all patterns that waits per request unless back to back
  task automatic run_phase(input bit back_to_back);
    int i;
    for (i = 0; i < num_patterns; i++) begin
      send_request(i);
      if (timeout_count != 0) return;
      if (!back_to_back) begin
        wait_for_responses(tx_count);
        if (timeout_count != 0) return;
      end
    end
    wait_for_responses(tx_count);
  endtask

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    req_val       = 1'b0;
    req_msg       = '0;
    resp_rdy      = 1'b1;
    cycle         = 0;
    tx_count      = 0;
    rx_count      = 0;
    error_count   = 0;
    timeout_count = 0;
    random_ready  = 1'b0;
    check_latency = 1'b1;
    val_seen      = 1'b0;
    $readmemh("testbench/imuldiv_patterns.txt", patterns);
    num_patterns = 0;
    while (num_patterns < MAX_PATTERNS && !$isunknown(patterns[num_patterns])) begin
      num_patterns++;
    end
    repeat (5) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    // idle state straight out of reset
    @(negedge clk);
    check_value("req_rdy", 64'd1, req_rdy);
    check_value("resp_val", 64'd0, resp_val);
    @(posedge clk);
    #DRIVE_DELAY;
    if (num_patterns == 0) begin
      $display("no patterns could be read from the pattern file");
      error_count++;
    end else begin
      // one at a time with ready high and the latency checked
      run_phase(1'b0);
      if (timeout_count == 0) begin
        @(negedge clk);
        check_latency = 1'b0;
        random_ready  = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        run_phase(1'b1);
      end
    end
    $display("%0d requests, %0d responses, %0d errors, %0d timeouts",
             tx_count, rx_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
